/* bench/cache_bank_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank_tb;

  localparam int MSHR_DEPTH   = 2;
  localparam int CLK_HALF     = 5;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_REQS     = 400;
  // Each new request brings at most one fill
  localparam int TIMEOUT_CYCLES = 20 * 2 * NUM_REQS + RESET_CYCLES;

  typedef struct packed {
    logic              from_bus;
    logic              uc;
    logic              rd;
    logic              wr;
    cache_pkg::mask_t  mask;
    cache_pkg::line_t  data;
    cache_pkg::paddr_t addr;
  } req_t;

  typedef struct packed {
    logic              ex_valid;
    cache_pkg::line_t  ex_data;
    logic              miss;
    logic              s0_valid;
    cache_pkg::paddr_t s0_addr;
    cache_pkg::line_t  s0_data;
    logic              s0_rw;
    logic [3:0]        s0_dest;
    logic              s1_valid;
    cache_pkg::paddr_t s1_addr;
    logic [3:0]        s1_dest;
    logic              s1_uc;
  } expect_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req_valid;
  cache_pkg::paddr_t req_addr;
  cache_pkg::line_t  req_data;
  cache_pkg::mask_t  req_mask;
  logic              req_rd;
  logic              req_wr;
  logic              req_from_bus;
  logic              req_uncached;
  logic              ser0_full;
  logic              ser1_full;
  logic              aq_read;
  logic              ser0_valid;
  cache_pkg::paddr_t ser0_addr;
  cache_pkg::line_t  ser0_data;
  logic              ser0_rw;
  logic [15:0]       ser0_size;
  logic [3:0]        ser0_dest;
  logic              ser1_valid;
  cache_pkg::paddr_t ser1_addr;
  logic [15:0]       ser1_size;
  logic [3:0]        ser1_dest;
  logic              ex_valid;
  cache_pkg::line_t  ex_data;
  logic              cache_stall;
  logic              cache_miss;
  logic              mshr_full;

  logic [31:0] lfsr = 32'haad5c584;
  int          checks = 0;
  int          errors = 0;
  int          hits = 0;
  int          misses = 0;
  int          extracts = 0;
  int          stall_cycles = 0;
  req_t        fill_q [$];
  req_t        cur_req;

  // Reference state of the bank
  cache_pkg::tag_t   m_tag   [4][4];
  logic              m_valid [4][4];
  logic              m_dirty [4][4];
  logic [1:0]        m_age   [4][4];
  cache_pkg::line_t  m_line  [4][4];
  cache_pkg::paddr_t m_mshr_addr  [MSHR_DEPTH];
  logic              m_mshr_valid [MSHR_DEPTH];

  cache_bank #(
    .MSHR_DEPTH (MSHR_DEPTH)
  ) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_mask     (req_mask),
    .req_rd       (req_rd),
    .req_wr       (req_wr),
    .req_from_bus (req_from_bus),
    .req_uncached (req_uncached),
    .aq_read      (aq_read),
    .ser0_full    (ser0_full),
    .ser1_full    (ser1_full),
    .ser0_valid   (ser0_valid),
    .ser0_addr    (ser0_addr),
    .ser0_data    (ser0_data),
    .ser0_rw      (ser0_rw),
    .ser0_size    (ser0_size),
    .ser0_dest    (ser0_dest),
    .ser1_valid   (ser1_valid),
    .ser1_addr    (ser1_addr),
    .ser1_size    (ser1_size),
    .ser1_dest    (ser1_dest),
    .ex_valid     (ex_valid),
    .ex_data      (ex_data),
    .cache_stall  (cache_stall),
    .cache_miss   (cache_miss),
    .mshr_full    (mshr_full)
  );

  always #CLK_HALF clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        out;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
        lfsr = lfsr ^ 32'h80200003;
      end
      bits = {bits[30:0], out};
    end
    return bits;
  endfunction

  function automatic cache_pkg::line_t fill_data();
    cache_pkg::line_t d;
    for (int i = 0; i < 4; i++) begin
      d[32*i +: 32] = take_bits(32);
    end
    return d;
  endfunction

  // Small tag pool so that sets conflict
  function automatic cache_pkg::tag_t pool_tag(input int i);
    case (i)
      0:       return 8'h11;
      1:       return 8'h2a;
      2:       return 8'h35;
      3:       return 8'h4c;
      4:       return 8'h93;
      default: return 8'he7;
    endcase
  endfunction

  function automatic req_t random_request();
    req_t       r;
    logic [3:0] kind;
    logic [2:0] pick;
    logic [1:0] index;
    logic [3:0] offset;
    r      = '0;
    kind   = 4'(take_bits(4));
    pick   = 3'(take_bits(3));
    index  = 2'(take_bits(2));
    offset = 4'(take_bits(4));
    // Bank bit stays 0 for bank 0
    r.addr = {pool_tag(pick % 6), index, 1'b0, offset};
    r.data = fill_data();
    r.mask = 16'(take_bits(16));
    r.uc   = (kind >= 4'd14);
    r.wr   = (kind == 4'd15) || (kind >= 4'd8 && kind <= 4'd12);
    r.rd   = !r.wr;
    return r;
  endfunction

  task automatic present(input req_t r);
    cur_req      = r;
    req_valid    <= 1'b1;
    req_addr     <= r.addr;
    req_data     <= r.data;
    req_mask     <= r.mask;
    req_rd       <= r.rd;
    req_wr       <= r.wr;
    req_from_bus <= r.from_bus;
    req_uncached <= r.uc;
  endtask

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic void reset_model();
    for (int s = 0; s < 4; s++) begin
      for (int w = 0; w < 4; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_age[s][w]   = 2'(3 - w);
      end
    end
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      m_mshr_valid[i] = 1'b0;
    end
  endfunction

  function automatic int find_hit(input cache_pkg::paddr_t a);
    int h;
    h = -1;
    for (int w = 0; w < 4; w++) begin
      if (m_valid[a[6:5]][w] && m_tag[a[6:5]][w] == a[14:7]) begin
        h = w;
      end
    end
    return h;
  endfunction

  function automatic int find_mshr(input cache_pkg::paddr_t a);
    int e;
    e = -1;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (m_mshr_valid[i] && m_mshr_addr[i][14:4] == a[14:4]) begin
        e = i;
      end
    end
    return e;
  endfunction

  function automatic logic mshr_is_full();
    logic f;
    f = 1'b1;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      f = f & m_mshr_valid[i];
    end
    return f;
  endfunction

  // Lowest invalid way or else the oldest one
  function automatic int pick_victim(input int s);
    int v;
    v = -1;
    for (int w = 0; w < 4; w++) begin
      if (v < 0 && !m_valid[s][w]) begin
        v = w;
      end
    end
    if (v < 0) begin
      v = 0;
      for (int w = 1; w < 4; w++) begin
        if (m_age[s][w] > m_age[s][v]) begin
          v = w;
        end
      end
    end
    return v;
  endfunction

  function automatic void touch(input int s, input int w);
    logic [1:0] a;
    a = m_age[s][w];
    for (int i = 0; i < 4; i++) begin
      if (m_age[s][i] < a) begin
        m_age[s][i] = m_age[s][i] + 2'd1;
      end
    end
    m_age[s][w] = 2'd0;
  endfunction

  function automatic logic predict_stall(input req_t r);
    int s;
    int w;
    s = r.addr[6:5];
    if (r.from_bus) begin
      return 1'b0;
    end
    if (r.uc) begin
      return r.wr ? ser0_full : ser1_full;
    end
    if (find_hit(r.addr) >= 0 || find_mshr(r.addr) >= 0) begin
      return 1'b0;
    end
    w = pick_victim(s);
    return mshr_is_full() || ser1_full || (ser0_full && m_valid[s][w] && m_dirty[s][w]);
  endfunction

  // Applies one accepted request to the reference state
  function automatic expect_t apply_request(input req_t r);
    expect_t          e;
    int               s;
    int               w;
    int               ent;
    logic [3:0]       mem_dest;
    cache_pkg::line_t merged;
    e        = '0;
    s        = r.addr[6:5];
    mem_dest = {cache_pkg::DEST_MEMORY[3:2], r.addr[5:4]};
    if (r.from_bus) begin
      e.ex_valid = 1'b1;
      e.ex_data  = r.data;
      if (!r.uc) begin
        w            = pick_victim(s);
        m_tag[s][w]   = r.addr[14:7];
        m_valid[s][w] = 1'b1;
        m_dirty[s][w] = 1'b0;
        m_line[s][w]  = r.data;
        touch(s, w);
        ent = find_mshr(r.addr);
        if (ent >= 0) begin
          m_mshr_valid[ent] = 1'b0;
        end
      end
    end else if (r.uc) begin
      if (r.wr) begin
        e.s0_valid = 1'b1;
        e.s0_addr  = r.addr;
        e.s0_data  = r.data;
        e.s0_rw    = 1'b1;
        e.s0_dest  = cache_pkg::DEST_IO;
      end else begin
        e.s1_valid = 1'b1;
        e.s1_addr  = r.addr;
        e.s1_dest  = cache_pkg::DEST_IO;
        e.s1_uc    = 1'b1;
      end
    end else begin
      w = find_hit(r.addr);
      if (w >= 0) begin
        merged = m_line[s][w];
        if (r.wr) begin
          for (int b = 0; b < 16; b++) begin
            if (r.mask[b]) begin
              merged[8*b +: 8] = r.data[8*b +: 8];
            end
          end
          m_dirty[s][w] = 1'b1;
        end
        m_line[s][w] = merged;
        e.ex_valid   = 1'b1;
        e.ex_data    = merged;
        touch(s, w);
      end else begin
        e.miss = 1'b1;
        if (find_mshr(r.addr) < 0) begin
          w = pick_victim(s);
          if (m_valid[s][w] && m_dirty[s][w]) begin
            e.s0_valid = 1'b1;
            e.s0_addr  = {m_tag[s][w], r.addr[6:4], 4'b0000};
            e.s0_data  = m_line[s][w];
            e.s0_rw    = 1'b1;
            e.s0_dest  = mem_dest;
          end
          m_valid[s][w] = 1'b0;
          m_dirty[s][w] = 1'b0;
          ent = -1;
          for (int i = MSHR_DEPTH - 1; i >= 0; i--) begin
            if (!m_mshr_valid[i]) begin
              ent = i;
            end
          end
          m_mshr_valid[ent] = 1'b1;
          m_mshr_addr[ent]  = {r.addr[14:4], 4'b0000};
          e.s1_valid = 1'b1;
          e.s1_addr  = {r.addr[14:4], 4'b0000};
          e.s1_dest  = mem_dest;
        end
      end
    end
    return e;
  endfunction

  // Compare process samples in the middle of each cycle
  initial begin
    expect_t e;
    req_t    r;
    req_t    fill;
    logic    stall;
    e = '0;
    reset_model();
    forever begin
      @(negedge clk);
      if (rst_n) begin
        check("ex_valid", ex_valid, e.ex_valid);
        if (e.ex_valid) begin
          check("ex_data", ex_data, e.ex_data);
        end
        check("cache_miss", cache_miss, e.miss);
        check("ser0_valid", ser0_valid, e.s0_valid);
        if (e.s0_valid) begin
          check("ser0_addr", ser0_addr, e.s0_addr);
          check("ser0_data", ser0_data, e.s0_data);
          check("ser0_rw", ser0_rw, e.s0_rw);
          check("ser0_size", ser0_size, cache_pkg::SER_SIZE_LINE);
          check("ser0_dest", ser0_dest, e.s0_dest);
        end
        check("ser1_valid", ser1_valid, e.s1_valid);
        if (e.s1_valid) begin
          check("ser1_addr", ser1_addr, e.s1_addr);
          check("ser1_size", ser1_size, cache_pkg::SER_SIZE_READ);
          check("ser1_dest", ser1_dest, e.s1_dest);
          // The bus answers every ser1 read with a fill
          fill          = '0;
          fill.addr     = e.s1_addr;
          fill.from_bus = 1'b1;
          fill.uc       = e.s1_uc;
          fill_q.push_back(fill);
        end
        check("mshr_full", mshr_full, mshr_is_full());
        r = {req_from_bus, req_uncached, req_rd, req_wr, req_mask, req_data, req_addr};
        stall = predict_stall(r);
        check("cache_stall", cache_stall, req_valid && stall);
        check("aq_read", aq_read, req_valid && !stall);
        e = '0;
        if (req_valid && stall) begin
          stall_cycles++;
        end else if (req_valid) begin
          e = apply_request(r);
          if (e.miss) begin
            misses++;
          end
          if (e.ex_valid && !r.from_bus) begin
            hits++;
          end
          if (e.s0_valid && !r.uc) begin
            extracts++;
          end
        end
      end
    end
  end

  // Stimulus
  initial begin
    req_t retry_req;
    req_t r;
    logic have_retry;
    logic coin;
    int   issued;
    int   waited;
    int   quiet;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_data     = '0;
    req_mask     = '0;
    req_rd       = 1'b0;
    req_wr       = 1'b0;
    req_from_bus = 1'b0;
    req_uncached = 1'b0;
    ser0_full    = 1'b0;
    ser1_full    = 1'b0;
    cur_req      = '0;
    have_retry   = 1'b0;
    issued       = 0;
    waited       = 0;
    quiet        = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    while (quiet < 4) begin
      @(posedge clk);
      ser0_full <= (3'(take_bits(3)) == 3'b111);
      ser1_full <= (3'(take_bits(3)) == 3'b111);
      coin = 1'(take_bits(1));
      if (req_valid && !aq_read) begin
        quiet = 0;
        waited++;
        // A long stall on a full table steps aside to let a fill in
        if (waited >= 6 && fill_q.size() > 0 && !cur_req.from_bus && !have_retry) begin
          retry_req  = cur_req;
          have_retry = 1'b1;
          waited     = 0;
          r          = fill_q.pop_front();
          r.data     = fill_data();
          present(r);
        end
      end else begin
        waited = 0;
        if (fill_q.size() > 0 && (coin || issued >= NUM_REQS)) begin
          r      = fill_q.pop_front();
          r.data = fill_data();
          present(r);
          quiet = 0;
        end else if (have_retry) begin
          present(retry_req);
          have_retry = 1'b0;
          quiet      = 0;
        end else if (issued < NUM_REQS) begin
          present(random_request());
          issued++;
          quiet = 0;
        end else begin
          req_valid <= 1'b0;
          quiet++;
        end
      end
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d, hits %0d, misses %0d, extracts %0d, stall cycles %0d",
             checks, errors, hits, misses, extracts, stall_cycles);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * 2 * CLK_HALF);
    $display("timeout: the run did not finish within %0d cycles, %0d errors so far",
             TIMEOUT_CYCLES, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/cache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/mshr_table.sv
verilog/cache_bank_ctrl.sv
verilog/cache_bank.sv
bench/cache_bank_tb.sv

/* verilog/cache_array_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface cache_array_if;

  // Lookup and update signals from the controller
  cache_pkg::index_t index;
  cache_pkg::tag_t   tag;
  logic              lookup;
  logic              fill_en;
  cache_pkg::way_t   fill_way;
  cache_pkg::tag_t   fill_tag;
  cache_pkg::line_t  fill_line;
  logic              write_en;
  cache_pkg::way_t   write_way;
  cache_pkg::mask_t  write_mask;
  cache_pkg::line_t  write_line;
  logic              invalidate_en;
  cache_pkg::way_t   invalidate_way;

  // Tag array results
  logic              hit;
  cache_pkg::way_t   hit_way;
  cache_pkg::way_t   victim_way;
  logic              victim_valid;
  logic              victim_dirty;
  cache_pkg::tag_t   victim_tag;

  // Data array results
  cache_pkg::line_t  read_line;
  cache_pkg::line_t  victim_line;

  modport ctrl (
    output index, tag, lookup, fill_en, fill_way, fill_tag, fill_line,
    output write_en, write_way, write_mask, write_line, invalidate_en, invalidate_way,
    input  hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag,
    input  read_line, victim_line
  );

  modport array (
    input  index, tag, lookup, fill_en, fill_way, fill_tag, fill_line,
    input  write_en, write_way, write_mask, write_line, invalidate_en, invalidate_way,
    output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag,
    output read_line, victim_line
  );

endinterface

`default_nettype wire

/* verilog/cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank #(
  parameter int MSHR_DEPTH = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_valid,
  input  wire cache_pkg::paddr_t req_addr,
  input  wire cache_pkg::line_t  req_data,
  input  wire cache_pkg::mask_t  req_mask,
  input  wire logic              req_rd,
  input  wire logic              req_wr,
  input  wire logic              req_from_bus,
  input  wire logic              req_uncached,
  output logic                   aq_read,
  input  wire logic              ser0_full,
  input  wire logic              ser1_full,
  output logic                   ser0_valid,
  output cache_pkg::paddr_t      ser0_addr,
  output cache_pkg::line_t       ser0_data,
  output logic                   ser0_rw,
  output logic [15:0]            ser0_size,
  output logic [3:0]             ser0_dest,
  output logic                   ser1_valid,
  output cache_pkg::paddr_t      ser1_addr,
  output logic [15:0]            ser1_size,
  output logic [3:0]             ser1_dest,
  output logic                   ex_valid,
  output cache_pkg::line_t       ex_data,
  output logic                   cache_stall,
  output logic                   cache_miss,
  output logic                   mshr_full
);

  logic              mshr_alloc;
  logic              mshr_free;
  logic              mshr_match;
  cache_pkg::paddr_t mshr_addr;

  cache_array_if arr_if ();

  cache_bank_ctrl #(
    .MSHR_DEPTH (MSHR_DEPTH)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_mask     (req_mask),
    .req_rd       (req_rd),
    .req_wr       (req_wr),
    .req_from_bus (req_from_bus),
    .req_uncached (req_uncached),
    .ser0_full    (ser0_full),
    .ser1_full    (ser1_full),
    .mshr_match   (mshr_match),
    .mshr_full    (mshr_full),
    .aq_read      (aq_read),
    .cache_stall  (cache_stall),
    .mshr_alloc   (mshr_alloc),
    .mshr_free    (mshr_free),
    .mshr_addr    (mshr_addr),
    .ser0_valid   (ser0_valid),
    .ser0_addr    (ser0_addr),
    .ser0_data    (ser0_data),
    .ser0_rw      (ser0_rw),
    .ser0_size    (ser0_size),
    .ser0_dest    (ser0_dest),
    .ser1_valid   (ser1_valid),
    .ser1_addr    (ser1_addr),
    .ser1_size    (ser1_size),
    .ser1_dest    (ser1_dest),
    .ex_valid     (ex_valid),
    .ex_data      (ex_data),
    .cache_miss   (cache_miss),
    .arr          (arr_if.ctrl)
  );

  cache_tag_array u_tags (
    .clk   (clk),
    .rst_n (rst_n),
    .arr   (arr_if.array)
  );

  cache_data_array u_data (
    .clk (clk),
    .arr (arr_if.array)
  );

  mshr_table #(
    .MSHR_DEPTH (MSHR_DEPTH)
  ) u_mshr (
    .clk   (clk),
    .rst_n (rst_n),
    .alloc (mshr_alloc),
    .free  (mshr_free),
    .addr  (mshr_addr),
    .match (mshr_match),
    .full  (mshr_full)
  );

endmodule

`default_nettype wire

/* verilog/cache_bank_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank_ctrl #(
  parameter int MSHR_DEPTH = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_valid,
  input  wire cache_pkg::paddr_t req_addr,
  input  wire cache_pkg::line_t  req_data,
  input  wire cache_pkg::mask_t  req_mask,
  input  wire logic              req_rd,
  input  wire logic              req_wr,
  input  wire logic              req_from_bus,
  input  wire logic              req_uncached,
  input  wire logic              ser0_full,
  input  wire logic              ser1_full,
  input  wire logic              mshr_match,
  input  wire logic              mshr_full,
  output logic                   aq_read,
  output logic                   cache_stall,
  output logic                   mshr_alloc,
  output logic                   mshr_free,
  output cache_pkg::paddr_t      mshr_addr,
  output logic                   ser0_valid,
  output cache_pkg::paddr_t      ser0_addr,
  output cache_pkg::line_t       ser0_data,
  output logic                   ser0_rw,
  output logic [15:0]            ser0_size,
  output logic [3:0]             ser0_dest,
  output logic                   ser1_valid,
  output cache_pkg::paddr_t      ser1_addr,
  output logic [15:0]            ser1_size,
  output logic [3:0]             ser1_dest,
  output logic                   ex_valid,
  output cache_pkg::line_t       ex_data,
  output logic                   cache_miss,
  cache_array_if.ctrl            arr
);

  cache_pkg::req_kind_t kind;
  logic                 accept;
  logic                 extract;
  logic                 victim_dirty;
  logic [3:0]           mem_dest;
  cache_pkg::paddr_t    victim_addr;

  // Classify the request at the head of the queue
  always_comb begin
    kind = cache_pkg::KIND_IDLE;
    if (req_valid) begin
      if (req_from_bus) begin
        kind = req_uncached ? cache_pkg::KIND_UC_FILL : cache_pkg::KIND_FILL;
      end else if (req_uncached) begin
        if (req_wr) begin
          kind = cache_pkg::KIND_UC_WRITE;
        end else if (req_rd) begin
          kind = cache_pkg::KIND_UC_READ;
        end
      end else if (req_rd || req_wr) begin
        if (arr.hit) begin
          kind = cache_pkg::KIND_HIT;
        end else if (mshr_match) begin
          kind = cache_pkg::KIND_SECONDARY;
        end else begin
          kind = cache_pkg::KIND_MISS;
        end
      end
    end
  end

  // A victim needs an extract only when it holds a modified line
  assign victim_dirty = arr.victim_valid & arr.victim_dirty;

  // Resource checks
  always_comb begin
    case (kind)
      cache_pkg::KIND_MISS:
        cache_stall = mshr_full | ser1_full | (ser0_full & victim_dirty);
      cache_pkg::KIND_UC_READ:  cache_stall = ser1_full;
      cache_pkg::KIND_UC_WRITE: cache_stall = ser0_full;
      default:                  cache_stall = 1'b0;
    endcase
  end

  assign accept  = req_valid & ~cache_stall;
  assign aq_read = accept;
  assign extract = (kind == cache_pkg::KIND_MISS) & victim_dirty;

  assign mem_dest    = {cache_pkg::DEST_MEMORY[3:2], req_addr[5:4]};
  assign victim_addr = {arr.victim_tag, req_addr[6:4], 4'b0000};

  // Array lookup and updates
  assign arr.index          = cache_pkg::addr_index(req_addr);
  assign arr.tag            = cache_pkg::addr_tag(req_addr);
  assign arr.lookup         = accept & (kind == cache_pkg::KIND_HIT);
  assign arr.fill_en        = accept & (kind == cache_pkg::KIND_FILL);
  assign arr.fill_way       = arr.victim_way;
  assign arr.fill_tag       = cache_pkg::addr_tag(req_addr);
  assign arr.fill_line      = req_data;
  assign arr.write_en       = accept & (kind == cache_pkg::KIND_HIT) & req_wr;
  assign arr.write_way      = arr.hit_way;
  assign arr.write_mask     = req_mask;
  assign arr.write_line     = req_data;
  assign arr.invalidate_en  = accept & (kind == cache_pkg::KIND_MISS);
  assign arr.invalidate_way = arr.victim_way;

  // Miss table
  assign mshr_alloc = accept & (kind == cache_pkg::KIND_MISS);
  assign mshr_free  = accept & (kind == cache_pkg::KIND_FILL);
  assign mshr_addr  = req_addr;

  // Output pulses one cycle after acceptance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid   <= 1'b0;
      cache_miss <= 1'b0;
      ser0_valid <= 1'b0;
      ser1_valid <= 1'b0;
    end else begin
      ex_valid   <= accept & (kind == cache_pkg::KIND_HIT || kind == cache_pkg::KIND_FILL ||
                              kind == cache_pkg::KIND_UC_FILL);
      cache_miss <= accept & (kind == cache_pkg::KIND_MISS ||
                              kind == cache_pkg::KIND_SECONDARY);
      ser0_valid <= accept & (extract || kind == cache_pkg::KIND_UC_WRITE);
      ser1_valid <= accept & (kind == cache_pkg::KIND_MISS || kind == cache_pkg::KIND_UC_READ);
    end
  end

  // Payload fields
  always_ff @(posedge clk) begin
    if (accept) begin
      // Write hit returns the merged line
      if (kind == cache_pkg::KIND_HIT) begin
        ex_data <= cache_pkg::merge_line(arr.read_line, req_data, req_wr ? req_mask : '0);
      end else begin
        ex_data <= req_data;
      end
      if (req_uncached) begin
        ser0_addr <= req_addr;
        ser0_data <= req_data;
        ser0_rw   <= req_wr;
        ser0_dest <= cache_pkg::DEST_IO;
        ser1_addr <= req_addr;
        ser1_dest <= cache_pkg::DEST_IO;
      end else begin
        // Extract of the victim line
        ser0_addr <= victim_addr;
        ser0_data <= arr.victim_line;
        ser0_rw   <= 1'b1;
        ser0_dest <= mem_dest;
        ser1_addr <= cache_pkg::line_addr(req_addr);
        ser1_dest <= mem_dest;
      end
      ser0_size <= cache_pkg::SER_SIZE_LINE;
      ser1_size <= cache_pkg::SER_SIZE_READ;
    end
  end

endmodule

`default_nettype wire

/* verilog/cache_data_array.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_data_array (
  input  wire logic   clk,
  cache_array_if.array arr
);

  localparam int NW = cache_pkg::NUM_WAYS;
  localparam int NS = cache_pkg::NUM_SETS;

  cache_pkg::line_t line_q [NS][NW];

  // Hit and victim lines of the indexed set
  assign arr.read_line   = line_q[arr.index][arr.hit_way];
  assign arr.victim_line = line_q[arr.index][arr.victim_way];

  always_ff @(posedge clk) begin
    if (arr.fill_en) begin
      line_q[arr.index][arr.fill_way] <= arr.fill_line;
    end
    if (arr.write_en) begin
      // Only enabled bytes change
      line_q[arr.index][arr.write_way] <= cache_pkg::merge_line(
          line_q[arr.index][arr.write_way], arr.write_line, arr.write_mask);
    end
  end

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // Physical address holds tag [14:7], set [6:5], bank [4] and offset [3:0]
  typedef logic [14:0]  paddr_t;
  typedef logic [7:0]   tag_t;
  typedef logic [1:0]   index_t;
  typedef logic [1:0]   way_t;
  typedef logic [127:0] line_t;
  typedef logic [15:0]  mask_t;

  localparam int NUM_WAYS = 4;
  localparam int NUM_SETS = 4;

  // Serializer size and destination codes
  localparam logic [15:0] SER_SIZE_LINE = 16'h8000;
  localparam logic [15:0] SER_SIZE_READ = 16'h1000;
  localparam logic [3:0]  DEST_MEMORY   = 4'b1000;
  localparam logic [3:0]  DEST_IO       = 4'b1100;

  // Request classes seen by the bank controller
  typedef enum logic [2:0] {
    KIND_IDLE,
    KIND_HIT,
    KIND_MISS,
    KIND_SECONDARY,
    KIND_FILL,
    KIND_UC_FILL,
    KIND_UC_READ,
    KIND_UC_WRITE
  } req_kind_t;

  function automatic tag_t addr_tag(paddr_t addr);
    return addr[14:7];
  endfunction

  function automatic index_t addr_index(paddr_t addr);
    return addr[6:5];
  endfunction

  // Line address with the byte offset cleared
  function automatic paddr_t line_addr(paddr_t addr);
    return {addr[14:4], 4'b0000};
  endfunction

  // Replace the enabled bytes of a line
  function automatic line_t merge_line(line_t old_line, line_t new_line, mask_t mask);
    line_t result;
    result = old_line;
    for (int b = 0; b < 16; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = new_line[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

/* verilog/cache_tag_array.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_tag_array (
  input  wire logic   clk,
  input  wire logic   rst_n,
  cache_array_if.array arr
);

  localparam int NW = cache_pkg::NUM_WAYS;
  localparam int NS = cache_pkg::NUM_SETS;

  cache_pkg::tag_t tag_q   [NS][NW];
  logic            valid_q [NS][NW];
  logic            dirty_q [NS][NW];
  // Age 0 is youngest and NW-1 oldest
  logic [1:0]      age_q   [NS][NW];

  logic            touch_en;
  cache_pkg::way_t touch_way;

  // Tag compare across the indexed set
  always_comb begin
    arr.hit     = 1'b0;
    arr.hit_way = '0;
    for (int w = 0; w < NW; w++) begin
      if (valid_q[arr.index][w] && tag_q[arr.index][w] == arr.tag) begin
        arr.hit     = 1'b1;
        arr.hit_way = cache_pkg::way_t'(w);
      end
    end
  end

  // Victim is the lowest invalid way or else the oldest
  always_comb begin
    logic found;
    found          = 1'b0;
    arr.victim_way = '0;
    for (int w = 0; w < NW; w++) begin
      if (!found && !valid_q[arr.index][w]) begin
        found          = 1'b1;
        arr.victim_way = cache_pkg::way_t'(w);
      end
    end
    if (!found) begin
      for (int w = 1; w < NW; w++) begin
        if (age_q[arr.index][w] > age_q[arr.index][arr.victim_way]) begin
          arr.victim_way = cache_pkg::way_t'(w);
        end
      end
    end
  end

  assign arr.victim_valid = valid_q[arr.index][arr.victim_way];
  assign arr.victim_dirty = dirty_q[arr.index][arr.victim_way];
  assign arr.victim_tag   = tag_q[arr.index][arr.victim_way];

  assign touch_en  = arr.fill_en | (arr.lookup & arr.hit);
  assign touch_way = arr.fill_en ? arr.fill_way : arr.hit_way;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NS; s++) begin
        for (int w = 0; w < NW; w++) begin
          valid_q[s][w] <= 1'b0;
          dirty_q[s][w] <= 1'b0;
          age_q[s][w]   <= 2'(NW - 1 - w);
        end
      end
    end else begin
      if (arr.fill_en) begin
        tag_q[arr.index][arr.fill_way]   <= arr.fill_tag;
        valid_q[arr.index][arr.fill_way] <= 1'b1;
        dirty_q[arr.index][arr.fill_way] <= 1'b0;
      end
      if (arr.write_en) begin
        dirty_q[arr.index][arr.write_way] <= 1'b1;
      end
      if (arr.invalidate_en) begin
        valid_q[arr.index][arr.invalidate_way] <= 1'b0;
        dirty_q[arr.index][arr.invalidate_way] <= 1'b0;
      end
      // Touched way becomes youngest and younger ways age by one
      if (touch_en) begin
        for (int w = 0; w < NW; w++) begin
          if (w == touch_way) begin
            age_q[arr.index][w] <= 2'd0;
          end else if (age_q[arr.index][w] < age_q[arr.index][touch_way]) begin
            age_q[arr.index][w] <= age_q[arr.index][w] + 2'd1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mshr_table.sv */
`timescale 1ns/1ns
`default_nettype none

module mshr_table #(
  parameter int MSHR_DEPTH = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              alloc,
  input  wire logic              free,
  input  wire cache_pkg::paddr_t addr,
  output logic                   match,
  output logic                   full
);

  cache_pkg::paddr_t      addr_q  [MSHR_DEPTH];
  logic [MSHR_DEPTH-1:0]  valid_q;
  logic [MSHR_DEPTH-1:0]  hit_vec;
  logic [MSHR_DEPTH-1:0]  alloc_vec;

  // Entries hold line addresses with the offset cleared
  always_comb begin
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      hit_vec[i] = valid_q[i] && addr_q[i] == cache_pkg::line_addr(addr);
    end
  end

  // Lowest free entry
  always_comb begin
    logic found;
    found     = 1'b0;
    alloc_vec = '0;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (!found && !valid_q[i]) begin
        found        = 1'b1;
        alloc_vec[i] = 1'b1;
      end
    end
  end

  assign match = |hit_vec;
  assign full  = &valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < MSHR_DEPTH; i++) begin
        if (alloc && alloc_vec[i]) begin
          valid_q[i] <= 1'b1;
        end else if (free && hit_vec[i]) begin
          valid_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (alloc && alloc_vec[i]) begin
        addr_q[i] <= cache_pkg::line_addr(addr);
      end
    end
  end

endmodule

`default_nettype wire
